/* logic/composer_pkg.sv */
package composer_pkg;

   // stream and field widths
   localparam int data_width     = 64;
   localparam int ctrl_width     = 8;
   localparam int ip_addr_width  = 32;
   localparam int mac_addr_width = 48;
   localparam int num_shards     = 4;
   localparam int shard_width    = 2;
   localparam int frame_words    = 9; // module header + 8 packet words

   // module header: dst port 1, word count, src port 1, byte count
   localparam logic [data_width-1:0] netfpga_hdr_word = {
      16'h0001,
      16'(frame_words - 1),
      16'h0001,
      16'(8 * (frame_words - 1))
   };

   localparam logic [15:0] ether_type_ipv4 = 16'h0800;
   localparam logic [15:0] ip_ver_ihl_tos  = 16'h4510; // v4, 5 words, tos 0x10
   localparam logic [15:0] ip_total_len_kv = 16'h0032;
   localparam logic [15:0] ip_ident        = 16'hd431;
   localparam logic [15:0] ip_flags_frag   = 16'h0000;
   localparam logic [15:0] ip_ttl_proto    = 16'h1411; // ttl 0x14, udp
   localparam logic [15:0] udp_port_kv     = 16'h001e; // port 30 both ways
   localparam logic [15:0] udp_len_kv      = 16'h001e; // receiver ignores it

   localparam logic [ctrl_width-1:0] ctrl_module_hdr = 8'hff;
   localparam logic [ctrl_width-1:0] ctrl_mid        = 8'h00;
   localparam logic [ctrl_width-1:0] ctrl_last       = 8'h80;

   // per-shard addressing, index 0 is the rightmost entry
   localparam logic [num_shards-1:0][ip_addr_width-1:0] fpga_ip_table = {
      32'h2801_0101, // 40.1.1.1
      32'h1e01_0101, // 30.1.1.1
      32'h1401_0101, // 20.1.1.1
      32'h0a01_0101  // 10.1.1.1
   };

   localparam logic [num_shards-1:0][ip_addr_width-1:0] asst_ip_table = {
      32'h2801_0102,
      32'h1e01_0102,
      32'h1401_0102,
      32'h0a01_0102
   };

   localparam logic [num_shards-1:0][mac_addr_width-1:0] asst_mac_table = {
      48'h0014_d125_d09f,
      48'h0014_d126_5344,
      48'h0014_d117_6be2,
      48'h0014_d117_6bee
   };

   localparam logic [mac_addr_width-1:0] nf_src_mac = 48'h004e_4632_4300; // port 0

   // command bytes, sit at bits 47:40 of the command word
   localparam logic [7:0] cmd_flush  = 8'h0a;
   localparam logic [7:0] cmd_tcheck = 8'h0b;

   typedef enum logic {
      flush_req  = 1'b0,
      tcheck_req = 1'b1
   } req_kind_e;

   typedef struct packed {
      logic [31:0] key;
      logic [31:0] value;
   } kv_pair_t;

   typedef union packed {
      logic [data_width-1:0] raw;
      kv_pair_t              pair;
   } kv_word_u;

   typedef struct packed {
      req_kind_e kind;
      kv_pair_t  pair;
   } request_t;

   typedef struct packed {
      logic [ip_addr_width-1:0] src_ip;
      logic [ip_addr_width-1:0] dst_ip;
   } ip_hdr_fields_t;

   typedef struct packed {
      logic [data_width-1:0] data;
      logic [ctrl_width-1:0] ctrl;
   } stream_word_t;

endpackage

/* logic/accum_value_fifo.sv */
`timescale 1ns/1ps

module accum_value_fifo (
   input  logic        clk,
   input  logic        reset,
   input  logic        accum_valid,
   input  logic [31:0] accum_value,
   output logic        accum_ready,
   output logic        fifo_valid,
   output logic [31:0] fifo_value,
   input  logic        fifo_pop
);

   logic [31:0] mem [4];
   logic [1:0]  wr_ptr;
   logic [1:0]  rd_ptr;
   logic [2:0]  count; // 0..4
   logic        push;
   logic        pop;

   assign accum_ready = (count != 3'd4);
   assign fifo_valid  = (count != 3'd0);
   assign fifo_value  = mem[rd_ptr]; // head of queue

   assign push = accum_valid && accum_ready;
   assign pop  = fifo_pop && fifo_valid;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 2'd1; // wraps at four
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 2'd1;
         end
         case ({push, pop})
            2'b10:   count <= count + 3'd1;
            2'b01:   count <= count - 3'd1;
            default: count <= count; // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= accum_value;
      end
   end

endmodule

/* logic/request_arbiter.sv */
`timescale 1ns/1ps

module request_arbiter import composer_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fifo_valid,
   input  logic [31:0]            fifo_value,
   output logic                   fifo_pop,
   input  logic                   flush_valid,
   input  kv_word_u               flush_word,
   output logic                   flush_ready,
   input  logic [shard_width-1:0] shard_id,
   output logic                   req_valid,
   output request_t               req,
   input  logic                   req_ready,
   output ip_hdr_fields_t         ip_fields
);

   typedef enum logic [1:0] {
      a_idle,
      a_take,
      a_hold
   } arb_state_e;

   arb_state_e state;
   logic       take_tcheck; // source picked in idle
   logic       take_xfer;

   // pop or read one cycle after the pick
   assign fifo_pop    = (state == a_take) && take_tcheck && fifo_valid;
   assign flush_ready = (state == a_take) && !take_tcheck;
   assign take_xfer   = fifo_pop || (flush_ready && flush_valid);
   assign req_valid   = (state == a_hold);

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= a_idle;
         take_tcheck <= 1'b0;
      end else begin
         case (state)
            a_idle: begin
               if (fifo_valid) begin // termination checks first
                  take_tcheck <= 1'b1;
                  state       <= a_take;
               end else if (flush_valid) begin
                  take_tcheck <= 1'b0;
                  state       <= a_take;
               end
            end
            a_take: begin
               if (take_xfer) begin
                  state <= a_hold;
               end
            end
            a_hold: begin
               if (req_ready) begin
                  state <= a_idle; // only now look for the next one
               end
            end
            default: state <= a_idle;
         endcase
      end
   end

   // request payload and the matching address pair
   always_ff @(posedge clk) begin
      if (take_xfer) begin
         if (take_tcheck) begin
            req.kind       <= tcheck_req;
            req.pair.key   <= '0;
            req.pair.value <= fifo_value;
         end else begin
            req.kind <= flush_req;
            req.pair <= flush_word.pair;
         end
         ip_fields.src_ip <= fpga_ip_table[shard_id];
         ip_fields.dst_ip <= asst_ip_table[shard_id];
      end
   end

endmodule

/* logic/ip_checksum.sv */
`timescale 1ns/1ps

module ip_checksum import composer_pkg::*; (
   input  logic           clk,
   input  logic           reset,
   input  ip_hdr_fields_t ip_fields,
   output logic [15:0]    checksum
);

   logic [31:0] sum_fixed_src; // constant words plus source halves
   logic [31:0] sum_dst;
   logic [31:0] total;
   logic [16:0] fold_once;
   logic [15:0] fold_twice;

   // stage one
   always_ff @(posedge clk) begin
      if (reset) begin
         sum_fixed_src <= '0;
         sum_dst       <= '0;
      end else begin
         sum_fixed_src <= 32'(ip_ver_ihl_tos) + 32'(ip_total_len_kv)
                        + 32'(ip_ident) + 32'(ip_flags_frag)
                        + 32'(ip_ttl_proto)
                        + 32'(ip_fields.src_ip[31:16])
                        + 32'(ip_fields.src_ip[15:0]);
         sum_dst       <= 32'(ip_fields.dst_ip[31:16])
                        + 32'(ip_fields.dst_ip[15:0]);
      end
   end

   // end-around carry, two folds cover any carry out of the first
   assign total      = sum_fixed_src + sum_dst;
   assign fold_once  = 17'(total[15:0]) + 17'(total[31:16]);
   assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

   // stage two
   always_ff @(posedge clk) begin
      if (reset) begin
         checksum <= '0;
      end else begin
         checksum <= ~fold_twice;
      end
   end

endmodule

/* logic/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer import composer_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   req_valid,
   input  request_t               req,
   output logic                   req_ready,
   input  logic [shard_width-1:0] shard_id,
   input  logic [15:0]            checksum,
   output logic                   out_valid,
   output stream_word_t           out_word,
   input  logic                   out_ready
);

   typedef enum logic [3:0] {
      s_idle,
      s_wait_0,
      s_wait_1,
      s_hdr,    // module header
      s_eth_0,
      s_eth_1,
      s_ip_0,
      s_ip_1,
      s_ip_2,
      s_cmd,
      s_zero,
      s_kv      // last word of the frame
   } seq_state_e;

   seq_state_e               state;
   request_t                 req_q;
   logic [shard_width-1:0]   shard_q;
   logic [15:0]              csum_q;
   logic [mac_addr_width-1:0] dst_mac;
   logic [ip_addr_width-1:0]  src_ip;
   logic [ip_addr_width-1:0]  dst_ip;
   logic [7:0]               cmd_byte;

   assign req_ready = (state == s_idle);
   assign out_valid = (state >= s_hdr);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= s_idle;
      end else begin
         case (state)
            s_idle: begin
               if (req_valid) begin
                  state <= s_wait_0;
               end
            end
            s_wait_0: state <= s_wait_1;
            s_wait_1: state <= s_hdr; // checksum settled by now
            s_kv: begin
               if (out_ready) begin
                  state <= s_idle;
               end
            end
            default: begin
               if (out_ready) begin
                  state <= seq_state_e'(state + 4'd1);
               end
            end
         endcase
      end
   end

   // arbiter may already hold the next request, so keep our own copy
   always_ff @(posedge clk) begin
      if (state == s_idle && req_valid) begin
         req_q   <= req;
         shard_q <= shard_id;
      end
      if (state == s_wait_1) begin
         csum_q <= checksum;
      end
   end

   assign dst_mac  = asst_mac_table[shard_q];
   assign src_ip   = fpga_ip_table[shard_q];
   assign dst_ip   = asst_ip_table[shard_q];
   assign cmd_byte = (req_q.kind == tcheck_req) ? cmd_tcheck : cmd_flush;

   always_comb begin
      out_word.ctrl = ctrl_mid;
      out_word.data = '0;
      case (state)
         s_hdr: begin
            out_word.data = netfpga_hdr_word;
            out_word.ctrl = ctrl_module_hdr;
         end
         s_eth_0: out_word.data = {dst_mac, nf_src_mac[47:32]};
         s_eth_1: out_word.data = {nf_src_mac[31:0], ether_type_ipv4, ip_ver_ihl_tos};
         s_ip_0: begin
            out_word.data = {ip_total_len_kv, ip_ident, ip_flags_frag, ip_ttl_proto};
         end
         s_ip_1:  out_word.data = {csum_q, src_ip, dst_ip[31:16]};
         s_ip_2:  out_word.data = {dst_ip[15:0], udp_port_kv, udp_port_kv, udp_len_kv};
         s_cmd:   out_word.data = {16'h0000, cmd_byte, 40'h0};
         s_zero:  out_word.data = '0; // reserved word
         s_kv: begin
            out_word.data = req_q.pair;
            out_word.ctrl = ctrl_last;
         end
         default: begin
            out_word.data = '0;
            out_word.ctrl = ctrl_mid;
         end
      endcase
   end

endmodule

/* logic/packet_composer.sv */
`timescale 1ns/1ps

module packet_composer import composer_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   accum_valid,
   input  logic [31:0]            accum_value,
   output logic                   accum_ready,
   input  logic                   flush_valid,
   input  kv_word_u               flush_word,
   output logic                   flush_ready,
   input  logic [shard_width-1:0] shard_id,
   output logic                   out_valid,
   output stream_word_t           out_word,
   input  logic                   out_ready
);

   logic           fifo_valid;
   logic [31:0]    fifo_value;
   logic           fifo_pop;
   logic           req_valid;
   logic           req_ready;
   request_t       req;
   ip_hdr_fields_t ip_fields;
   logic [15:0]    checksum;

   accum_value_fifo u_fifo (
      .clk         (clk),
      .reset       (reset),
      .accum_valid (accum_valid),
      .accum_value (accum_value),
      .accum_ready (accum_ready),
      .fifo_valid  (fifo_valid),
      .fifo_value  (fifo_value),
      .fifo_pop    (fifo_pop)
   );

   request_arbiter u_arbiter (
      .clk         (clk),
      .reset       (reset),
      .fifo_valid  (fifo_valid),
      .fifo_value  (fifo_value),
      .fifo_pop    (fifo_pop),
      .flush_valid (flush_valid),
      .flush_word  (flush_word),
      .flush_ready (flush_ready),
      .shard_id    (shard_id),
      .req_valid   (req_valid),
      .req         (req),
      .req_ready   (req_ready),
      .ip_fields   (ip_fields)
   );

   ip_checksum u_checksum (
      .clk       (clk),
      .reset     (reset),
      .ip_fields (ip_fields),
      .checksum  (checksum)
   );

   frame_sequencer u_sequencer (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .shard_id  (shard_id),
      .checksum  (checksum),
      .out_valid (out_valid),
      .out_word  (out_word),
      .out_ready (out_ready)
   );

endmodule

/* verif/packet_composer_assert.sv */
`timescale 1ns/1ps

module packet_composer_assert import composer_pkg::*; (
   input logic         clk,
   input logic         reset,
   input logic         accum_ready,
   input logic         out_valid,
   input stream_word_t out_word,
   input logic         out_ready
);

   logic [3:0]            word_cnt; // transfers seen in the current frame
   logic [ctrl_width-1:0] ctrl_exp;
   logic                  xfer;

   assign xfer = out_valid && out_ready;

   // first word carries the module header, the ninth closes the frame
   assign ctrl_exp = (word_cnt == 4'd0) ? ctrl_module_hdr :
                     (word_cnt == 4'(frame_words - 1)) ? ctrl_last : ctrl_mid;

   always_ff @(posedge clk) begin
      if (reset) begin
         word_cnt <= '0;
      end else if (xfer) begin
         if (word_cnt == 4'(frame_words - 1)) begin
            word_cnt <= '0;
         end else begin
            word_cnt <= word_cnt + 4'd1;
         end
      end
   end

   idle_after_reset: assert property (
      @(posedge clk) reset |=> (!out_valid && accum_ready)
   ) else $error("output active or accumulator FIFO not ready right after reset");

   word_held: assert property (
      @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> $stable(out_word)
   ) else $error("output word changed while the consumer stalled");

   valid_held: assert property (
      @(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> out_valid
   ) else $error("out_valid dropped without a transfer");

   ctrl_order: assert property (
      @(posedge clk) disable iff (reset)
      xfer |-> (out_word.ctrl == ctrl_exp)
   ) else $error("control byte out of order for frame word %0d", word_cnt);

endmodule

bind packet_composer packet_composer_assert u_assert (
   .clk         (clk),
   .reset       (reset),
   .accum_ready (accum_ready),
   .out_valid   (out_valid),
   .out_word    (out_word),
   .out_ready   (out_ready)
);

/* verif/tb_packet_composer.sv */
`timescale 1ns/1ps

module tb_packet_composer import composer_pkg::*; ();

   localparam int handshake_timeout = 300; // cycles
   localparam int frame_timeout     = 300;

   logic                   clk;
   logic                   reset;
   logic                   accum_valid;
   logic [31:0]            accum_value;
   logic                   accum_ready;
   logic                   flush_valid;
   kv_word_u               flush_word;
   logic                   flush_ready;
   logic [shard_width-1:0] shard_id;
   logic                   out_valid;
   stream_word_t           out_word;
   logic                   out_ready;

   integer       seed = 32'h00dc_a4c0;
   logic         hold_output = 1'b0; // forces out_ready low
   stream_word_t captured_words [$];
   kv_pair_t     stim_pairs [9];
   logic [31:0]  accum_vals [5];
   kv_pair_t     tcheck_pair;
   int           errors = 0;
   int           tests_run = 0;
   int           tests_failed = 0;
   logic         stalled = 1'b0;

   packet_composer dut0 (
      .clk         (clk),
      .reset       (reset),
      .accum_valid (accum_valid),
      .accum_value (accum_value),
      .accum_ready (accum_ready),
      .flush_valid (flush_valid),
      .flush_word  (flush_word),
      .flush_ready (flush_ready),
      .shard_id    (shard_id),
      .out_valid   (out_valid),
      .out_word    (out_word),
      .out_ready   (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // consumer back-pressure
   initial begin
      integer rnd;
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         rnd = $random(seed);
         out_ready = hold_output ? 1'b0 : rnd[0];
      end
   end

   always @(posedge clk) begin
      if (!reset && out_valid && out_ready) begin
         captured_words.push_back(out_word);
      end
   end

   // header checksum over ten halfwords with the checksum field as zero
   function automatic logic [15:0] ipv4_checksum(input logic [31:0] src, input logic [31:0] dst);
      logic [15:0] halves [10];
      logic [31:0] sum;
      int          i;
      halves = '{ip_ver_ihl_tos, ip_total_len_kv, ip_ident, ip_flags_frag, ip_ttl_proto,
                 16'h0000, src[31:16], src[15:0], dst[31:16], dst[15:0]};
      sum = '0;
      for (i = 0; i < 10; i++) begin
         sum = sum + 32'(halves[i]);
      end
      while (sum[31:16] != 16'h0000) begin
         sum = 32'(sum[15:0]) + 32'(sum[31:16]);
      end
      return ~sum[15:0];
   endfunction

   function automatic stream_word_t expected_word(input int idx, input req_kind_e kind,
                                                  input logic [shard_width-1:0] shard,
                                                  input kv_pair_t pair);
      stream_word_t w;
      logic [31:0]  src_ip;
      logic [31:0]  dst_ip;
      logic [7:0]   cmd;
      src_ip = fpga_ip_table[shard];
      dst_ip = asst_ip_table[shard];
      cmd    = (kind == tcheck_req) ? cmd_tcheck : cmd_flush;
      w.ctrl = (idx == 0) ? ctrl_module_hdr : ((idx == frame_words - 1) ? ctrl_last : ctrl_mid);
      case (idx)
         0: w.data = netfpga_hdr_word;
         1: w.data = {asst_mac_table[shard], nf_src_mac[47:32]};
         2: w.data = {nf_src_mac[31:0], ether_type_ipv4, ip_ver_ihl_tos};
         3: w.data = {ip_total_len_kv, ip_ident, ip_flags_frag, ip_ttl_proto};
         4: w.data = {ipv4_checksum(src_ip, dst_ip), src_ip, dst_ip[31:16]};
         5: w.data = {dst_ip[15:0], udp_port_kv, udp_port_kv, udp_len_kv};
         6: w.data = {16'h0000, cmd, 40'h0};
         7: w.data = '0;
         default: w.data = pair; // key/value word
      endcase
      return w;
   endfunction

   task automatic set_output_hold(input logic hold);
      @(posedge clk);
      hold_output = hold;
   endtask

   task automatic send_flush(input logic [shard_width-1:0] shard, input kv_pair_t pair);
      int   waited;
      logic taken;
      if (stalled) return;
      waited = 0;
      taken  = 1'b0;
      @(negedge clk);
      shard_id        = shard;
      flush_word.pair = pair;
      flush_valid     = 1'b1;
      while (!taken && waited < handshake_timeout) begin
         taken  = flush_ready; // transfer on the coming rising edge
         waited = waited + 1;
         @(negedge clk);
      end
      flush_valid = 1'b0;
      if (!taken) begin
         $display("Stall at %0d ns: flush on shard %0d was not accepted within %0d cycles",
                  $time, shard, handshake_timeout);
         errors  = errors + 1;
         stalled = 1'b1;
      end
   endtask

   // back-to-back pushes of accum_vals[first] onward
   task automatic push_accum_burst(input int first, input int n);
      int idx;
      int waited;
      if (stalled) return;
      idx    = 0;
      waited = 0;
      @(negedge clk);
      while (idx < n && waited < handshake_timeout) begin
         accum_valid = 1'b1;
         accum_value = accum_vals[first + idx];
         if (accum_ready) begin
            idx = idx + 1;
         end
         waited = waited + 1;
         @(negedge clk);
      end
      accum_valid = 1'b0;
      if (idx < n) begin
         $display("Stall at %0d ns: accumulator FIFO took only %0d of %0d values",
                  $time, idx, n);
         errors  = errors + 1;
         stalled = 1'b1;
      end
   endtask

   task automatic expect_frame(input string label, input req_kind_e kind,
                               input logic [shard_width-1:0] shard, input kv_pair_t pair);
      stream_word_t got;
      stream_word_t exp;
      int           waited;
      int           i;
      if (stalled) return;
      waited = 0;
      while (captured_words.size() < frame_words && waited < frame_timeout) begin
         @(negedge clk);
         waited = waited + 1;
      end
      if (captured_words.size() < frame_words) begin
         $display("Stall at %0d ns: %s frame did not complete within %0d cycles",
                  $time, label, frame_timeout);
         errors  = errors + 1;
         stalled = 1'b1;
         return;
      end
      for (i = 0; i < frame_words; i++) begin
         got = captured_words.pop_front();
         exp = expected_word(i, kind, shard, pair);
         assert (got == exp) else begin
            $display("ERROR at %0d ns: %s frame word %0d is %h/%h, expected %h/%h",
                     $time, label, i, got.data, got.ctrl, exp.data, exp.ctrl);
            errors = errors + 1;
         end
      end
   endtask

   task automatic close_test(input string name, input int first_err);
      tests_run = tests_run + 1;
      if (errors != first_err) begin
         tests_failed = tests_failed + 1;
         $display("test %s: FAIL with %0d errors", name, errors - first_err);
      end else begin
         $display("test %s: pass", name);
      end
   endtask

   initial begin
      int first_err;
      int k;
      reset       = 1'b1;
      accum_valid = 1'b0;
      accum_value = '0;
      flush_valid = 1'b0;
      flush_word  = '0;
      shard_id    = '0;
      for (k = 0; k < 9; k++) begin
         stim_pairs[k].key   = $random(seed);
         stim_pairs[k].value = $random(seed);
      end
      for (k = 0; k < 5; k++) begin
         accum_vals[k] = $random(seed);
      end
      repeat (5) @(negedge clk);
      reset = 1'b0;

      first_err = errors;
      repeat (4) begin
         @(negedge clk);
         assert (!out_valid && accum_ready && !flush_ready) else begin
            $display("ERROR at %0d ns: composer not idle after reset", $time);
            errors = errors + 1;
         end
      end
      close_test("reset_idle", first_err);

      first_err = errors;
      for (k = 0; k < num_shards; k++) begin
         send_flush(shard_width'(k), stim_pairs[k]);
         expect_frame("flush", flush_req, shard_width'(k), stim_pairs[k]);
      end
      close_test("flush_per_shard", first_err);

      // arbiter busy so the accumulated value and the next flush meet in idle
      first_err = errors;
      set_output_hold(1'b1);
      send_flush(2'd2, stim_pairs[4]);
      send_flush(2'd2, stim_pairs[5]);
      push_accum_burst(4, 1);
      set_output_hold(1'b0);
      send_flush(2'd2, stim_pairs[6]);
      tcheck_pair.key   = '0;
      tcheck_pair.value = accum_vals[4];
      expect_frame("filler", flush_req, 2'd2, stim_pairs[4]);
      expect_frame("filler", flush_req, 2'd2, stim_pairs[5]);
      expect_frame("tcheck", tcheck_req, 2'd2, tcheck_pair);
      expect_frame("flush", flush_req, 2'd2, stim_pairs[6]);
      close_test("tcheck_priority", first_err);

      first_err = errors;
      set_output_hold(1'b1);
      send_flush(2'd3, stim_pairs[7]);
      send_flush(2'd3, stim_pairs[8]);
      push_accum_burst(0, 4);
      if (!stalled) begin
         assert (!accum_ready) else begin
            $display("ERROR at %0d ns: accum_ready still high with four values queued", $time);
            errors = errors + 1;
         end
      end
      set_output_hold(1'b0);
      expect_frame("filler", flush_req, 2'd3, stim_pairs[7]);
      expect_frame("filler", flush_req, 2'd3, stim_pairs[8]);
      for (k = 0; k < 4; k++) begin
         tcheck_pair.key   = '0;
         tcheck_pair.value = accum_vals[k];
         expect_frame("queued tcheck", tcheck_req, 2'd3, tcheck_pair);
      end
      if (!stalled) begin
         assert (captured_words.size() == 0) else begin
            $display("ERROR at %0d ns: %0d unexpected output words left over",
                     $time, captured_words.size());
            errors = errors + 1;
         end
      end
      close_test("fifo_buffering", first_err);

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* all.f */
logic/composer_pkg.sv
logic/accum_value_fifo.sv
logic/request_arbiter.sv
logic/ip_checksum.sv
logic/frame_sequencer.sv
logic/packet_composer.sv
verif/packet_composer_assert.sv
verif/tb_packet_composer.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_packet_composer -f all.f -o sim_packet_composer
./obj_dir/sim_packet_composer | tee "$log_file"

if grep -q "Finished with errors" "$log_file"; then
   echo "simulation failed, see $log_file"
   exit 1
fi
echo "simulation passed"
